/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mbist_cfg
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mbist_cfg_pkg.sv */
`include "mbist_cfg_settings.svh"

package mbist_cfg_pkg;

    // ------------------------------
    // Plain vector types
    // ------------------------------
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  reg_be_t;
    // Word index from address bits 5..2
    typedef logic [3:0]  reg_idx_t;
    typedef logic [7:0]  reg_addr_t;
    // Values past the lane count select nothing
    typedef logic [3:0]  lane_sel_t;
    typedef logic [`MBIST_NUM_LANES-1:0] lane_vec_t;
    typedef logic [3:0]  err_cnt_t;

    // ------------------------------
    // Per-lane packing
    // ------------------------------
    // One nibble of word 3
    typedef struct packed {
        logic reserved;
        logic load;
        logic run;
        logic en;
    } bist_lane_ctrl_t;

    // One byte of word 4 or 5
    typedef struct packed {
        err_cnt_t err_cnt;
        logic     zero;
        logic     correct;
        logic     error;
        logic     done;
    } bist_lane_status_t;

    // ------------------------------
    // Internal requests
    // ------------------------------
    typedef struct packed {
        logic      strobe;
        reg_idx_t  idx;
        reg_word_t data;
        reg_be_t   be;
    } reg_wr_t;

    typedef struct packed {
        logic      start;
        logic      rd_n_wr;
        reg_word_t data;
    } ser_cmd_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SHIFT,
        SER_DONE
    } ser_state_t;

endpackage

/* common/mbist_cfg_settings.svh */
`ifndef MBIST_CFG_SETTINGS_SVH
`define MBIST_CFG_SETTINGS_SVH

// Lane count and transfer length are fixed by the 32-bit word packing
`define MBIST_NUM_LANES     8
`define MBIST_SHIFT_LEN     32

// ------------------------------
// Register word indices
// ------------------------------
`define MBIST_IDX_SW0       4'd0
`define MBIST_IDX_SW1       4'd1
`define MBIST_IDX_LANE_SEL  4'd2
`define MBIST_IDX_LANE_CTRL 4'd3
`define MBIST_IDX_STATUS0   4'd4
`define MBIST_IDX_STATUS1   4'd5
`define MBIST_IDX_SER_WR    4'd6
`define MBIST_IDX_SER_RD    4'd7
`define MBIST_IDX_SER_LAST  4'd8
`define MBIST_IDX_ID1       4'd9
`define MBIST_IDX_ID2       4'd10
`define MBIST_IDX_ID3       4'd11

// ------------------------------
// Reset signatures
// ------------------------------
`define MBIST_RST_SW0       32'h4433_2211
`define MBIST_RST_SW1       32'hDDCC_BBAA
// Identification signature
`define MBIST_RST_ID1       32'h4C66_8354
// Build code
`define MBIST_RST_ID2       32'h2112_2021
// Revision 1.3
`define MBIST_RST_ID3       32'h0001_3000

`endif

/* serial_port/mbist_serial_port.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module mbist_serial_port (
    input  logic                     mclk,
    input  logic                     reset_n,
    // Command from the bus control
    input  mbist_cfg_pkg::ser_cmd_t  ser_cmd,
    input  mbist_cfg_pkg::lane_sel_t lane_sel,
    output logic                     ser_done,
    output mbist_cfg_pkg::reg_word_t ser_rdata,
    // Lane serial pins
    output mbist_cfg_pkg::lane_vec_t bist_sdi,
    output mbist_cfg_pkg::lane_vec_t bist_shift,
    input  mbist_cfg_pkg::lane_vec_t bist_sdo
);

    localparam int CNT_W = $clog2(`MBIST_SHIFT_LEN);

    mbist_cfg_pkg::ser_state_t state;
    logic [CNT_W-1:0]          bit_cnt;
    mbist_cfg_pkg::reg_word_t  shift_reg;
    logic                      shifting;
    logic                      sdo_sel;

    // ------------------------------
    // Shift FSM
    // ------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= mbist_cfg_pkg::SER_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                mbist_cfg_pkg::SER_IDLE: begin
                    if (ser_cmd.start) begin
                        state   <= mbist_cfg_pkg::SER_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                mbist_cfg_pkg::SER_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    // Last bit of the transfer
                    if (bit_cnt == CNT_W'(`MBIST_SHIFT_LEN - 1)) begin
                        state <= mbist_cfg_pkg::SER_DONE;
                    end
                end
                // Done lasts a single cycle
                mbist_cfg_pkg::SER_DONE: state <= mbist_cfg_pkg::SER_IDLE;
                default:                 state <= mbist_cfg_pkg::SER_IDLE;
            endcase
        end
    end

    assign shifting = (state == mbist_cfg_pkg::SER_SHIFT);
    assign ser_done = (state == mbist_cfg_pkg::SER_DONE);

    // ------------------------------
    // Shift register
    // ------------------------------
    // Write loads data and read loads zeros
    // LSB goes out first while sdo enters at the top
    always_ff @(posedge mclk) begin
        if (ser_cmd.start && (state == mbist_cfg_pkg::SER_IDLE)) begin
            shift_reg <= ser_cmd.rd_n_wr ? '0 : ser_cmd.data;
        end else if (shifting) begin
            shift_reg <= {sdo_sel, shift_reg[31:1]};
        end
    end

    // Held after done for word 8 reads
    assign ser_rdata = shift_reg;

    // ------------------------------
    // Lane routing
    // ------------------------------
    // No lane matches a select past the lane count
    always_comb begin
        sdo_sel = 1'b0;
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            if (lane_sel == mbist_cfg_pkg::lane_sel_t'(i)) begin
                sdo_sel       = bist_sdo[i];
                bist_shift[i] = shifting;
                bist_sdi[i]   = shifting & shift_reg[0];
            end else begin
                bist_shift[i] = 1'b0;
                bist_sdi[i]   = 1'b0;
            end
        end
    end

endmodule

/* src.f */
+incdir+common
common/mbist_cfg_pkg.sv
verilog/mbist_reg_ctrl.sv
verilog/mbist_cfg_regs.sv
serial_port/mbist_serial_port.sv
verilog/mbist_cfg_top.sv
tb/mbist_cfg_assertions.sv
tb/tb_mbist_cfg.sv

/* tb/mbist_cfg_assertions.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module mbist_cfg_assertions (
    input logic                     mclk,
    input logic                     reset_n,
    input logic                     reg_cs,
    input logic                     reg_ack,
    input mbist_cfg_pkg::lane_vec_t bist_shift,
    input mbist_cfg_pkg::lane_vec_t bist_sdi,
    input mbist_cfg_pkg::lane_sel_t lane_sel
);

    // Failure tallies per property
    int n_ack_pulse = 0;
    int n_ack_cs    = 0;
    int n_shift     = 0;
    int n_reset     = 0;
    int n_latency   = 0;
    int fail_total;

    mbist_cfg_pkg::lane_vec_t sel_mask;
    logic                     cs_q;
    logic [5:0]               lat;

    assign fail_total = n_ack_pulse + n_ack_cs + n_shift + n_reset + n_latency;

    // Selects past the lane count give an empty mask
    always_comb begin
        if (lane_sel < `MBIST_NUM_LANES) begin
            sel_mask = mbist_cfg_pkg::lane_vec_t'(1) << lane_sel;
        end else begin
            sel_mask = '0;
        end
    end

    // ------------------------------
    // Cycles since the cs rise
    // ------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cs_q <= 1'b0;
            lat  <= '0;
        end else begin
            cs_q <= reg_cs;
            if (reg_cs && !cs_q) begin
                lat <= 6'd1;
            end else if (lat != 6'd63) begin
                lat <= lat + 6'd1;
            end
        end
    end

    // Single-cycle ack
    a_ack_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
        reg_ack |=> !reg_ack)
        else begin
            $error("ack held longer than one cycle");
            n_ack_pulse++;
        end

    // Master still holds cs while ack is up
    a_ack_cs: assert property (@(posedge mclk) disable iff (!reset_n)
        reg_ack |-> reg_cs)
        else begin
            $error("ack raised without cs");
            n_ack_cs++;
        end

    // At most one lane shifting and only the selected one
    a_shift_lane: assert property (@(posedge mclk) disable iff (!reset_n)
        $onehot0(bist_shift) && ((bist_shift & ~sel_mask) == '0))
        else begin
            $error("shift on more than one lane or on an unselected lane");
            n_shift++;
        end

    // Quiet outputs right after reset release
    a_reset_quiet: assert property (@(posedge mclk)
        $rose(reset_n) |-> (bist_shift == '0 && bist_sdi == '0 && !reg_ack))
        else begin
            $error("outputs active in the cycle after reset");
            n_reset++;
        end

    // Register access or full serial transfer
    a_ack_latency: assert property (@(posedge mclk) disable iff (!reset_n)
        $rose(reg_ack) |-> (lat == 6'd2 || lat == 6'(`MBIST_SHIFT_LEN + 3)))
        else begin
            $error("ack arrived after an unexpected number of cycles");
            n_latency++;
        end

endmodule

bind mbist_cfg_top mbist_cfg_assertions u_assertions (
    .mclk       (mclk),
    .reset_n    (reset_n),
    .reg_cs     (reg_cs),
    .reg_ack    (reg_ack),
    .bist_shift (bist_shift),
    .bist_sdi   (bist_sdi),
    .lane_sel   (lane_sel)
);

/* tb/tb_mbist_cfg.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module tb_mbist_cfg;

    // About six times the length of the full run
    localparam int MAX_CYCLES = 3000;
    localparam int ACK_WAIT   = `MBIST_SHIFT_LEN + 8;

    logic                                           mclk = 1'b0;
    logic                                           reset_n;
    logic                                           reg_cs;
    logic                                           reg_wr;
    mbist_cfg_pkg::reg_addr_t                       reg_addr;
    mbist_cfg_pkg::reg_word_t                       reg_wdata;
    mbist_cfg_pkg::reg_be_t                         reg_be;
    mbist_cfg_pkg::reg_word_t                       reg_rdata;
    logic                                           reg_ack;
    mbist_cfg_pkg::lane_vec_t                       bist_en;
    mbist_cfg_pkg::lane_vec_t                       bist_run;
    mbist_cfg_pkg::lane_vec_t                       bist_load;
    mbist_cfg_pkg::lane_vec_t                       bist_sdi;
    mbist_cfg_pkg::lane_vec_t                       bist_shift;
    mbist_cfg_pkg::lane_vec_t                       bist_sdo;
    mbist_cfg_pkg::lane_vec_t                       bist_done;
    mbist_cfg_pkg::lane_vec_t                       bist_error;
    mbist_cfg_pkg::lane_vec_t                       bist_correct;
    mbist_cfg_pkg::err_cnt_t [`MBIST_NUM_LANES-1:0] bist_error_cnt;

    // Serial chain of each BIST engine
    mbist_cfg_pkg::reg_word_t chain      [`MBIST_NUM_LANES];
    mbist_cfg_pkg::reg_word_t chain_init [`MBIST_NUM_LANES];
    // Expected register contents
    mbist_cfg_pkg::reg_word_t model      [16];
    // Lane activity during the last access
    mbist_cfg_pkg::lane_vec_t seen_shift;
    mbist_cfg_pkg::lane_vec_t seen_sdi;
    int errors = 0;
    int cycles = 0;

    mbist_cfg_top mbist_cfg_top_inst (.*);

    always #50 mclk = ~mclk;

    // ------------------------------
    // BIST chain model
    // ------------------------------
    // sdo is bit 0 and sdi enters at bit 31
    always @(posedge mclk) begin
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            if (!reset_n) begin
                chain[i] <= chain_init[i];
            end else if (bist_shift[i]) begin
                chain[i] <= {bist_sdi[i], chain[i][31:1]};
            end
        end
    end

    // Chain output held low during reset
    always_comb begin
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            bist_sdo[i] = reset_n ? chain[i][0] : 1'b0;
        end
    end

    // Run limit
    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------
    // Checks and bus tasks
    // ------------------------------
    task automatic check_word(input string name, input mbist_cfg_pkg::reg_word_t got,
                              input mbist_cfg_pkg::reg_word_t exp);
        assert (got === exp) else begin
            $display("ERR %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    // One bus transfer with cs held through the ack cycle
    task automatic bus_access(input logic wr, input mbist_cfg_pkg::reg_idx_t idx,
                              input mbist_cfg_pkg::reg_word_t wdata,
                              input mbist_cfg_pkg::reg_be_t be,
                              output mbist_cfg_pkg::reg_word_t rdata);
        int waited;
        int acks;
        waited     = 0;
        acks       = 0;
        seen_shift = '0;
        seen_sdi   = '0;
        reg_cs     = 1'b1;
        reg_wr     = wr;
        reg_addr   = {2'b00, idx, 2'b00};
        reg_wdata  = wdata;
        reg_be     = be;
        do begin
            @(posedge mclk);
            #1;
            seen_shift = seen_shift | bist_shift;
            seen_sdi   = seen_sdi | bist_sdi;
            if (reg_ack) begin
                acks++;
            end
            waited++;
        end while (!reg_ack && waited < ACK_WAIT);
        rdata = reg_rdata;
        @(posedge mclk);
        #1;
        if (reg_ack) begin
            acks++;
        end
        reg_cs = 1'b0;
        reg_wr = 1'b0;
        // Idle cycle before the next request
        @(posedge mclk);
        #1;
        if (reg_ack) begin
            acks++;
        end
        assert (acks == 1) else begin
            $display("Access to word %0d was acknowledged %0d times", idx, acks);
            errors++;
        end
    endtask

    task automatic reg_write(input mbist_cfg_pkg::reg_idx_t idx,
                             input mbist_cfg_pkg::reg_word_t data,
                             input mbist_cfg_pkg::reg_be_t be);
        mbist_cfg_pkg::reg_word_t unused;
        bus_access(1'b1, idx, data, be, unused);
    endtask

    task automatic reg_read_check(input mbist_cfg_pkg::reg_idx_t idx,
                                  input mbist_cfg_pkg::reg_word_t exp);
        mbist_cfg_pkg::reg_word_t rd;
        bus_access(1'b0, idx, '0, 4'hf, rd);
        check_word($sformatf("reg_rdata word %0d", idx), rd, exp);
    endtask

    // Status byte per lane as err_cnt, zero, correct, error, done
    function automatic mbist_cfg_pkg::reg_word_t status_word(input int first);
        mbist_cfg_pkg::reg_word_t w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = {bist_error_cnt[first+k], 1'b0, bist_correct[first+k],
                           bist_error[first+k], bist_done[first+k]};
        end
        return w;
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        mbist_cfg_pkg::reg_word_t data;
        mbist_cfg_pkg::reg_word_t mask;
        mbist_cfg_pkg::reg_idx_t  idx;
        mbist_cfg_pkg::lane_vec_t exp_en;
        mbist_cfg_pkg::lane_vec_t exp_run;
        mbist_cfg_pkg::lane_vec_t exp_load;
        mbist_cfg_pkg::lane_vec_t lane_mask;
        mbist_cfg_pkg::reg_be_t   be;
        int lane;
        void'($urandom(32'hebdbc42f));
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            chain_init[i] = $urandom();
        end
        reset_n        = 1'b0;
        reg_cs         = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        reg_be         = '0;
        bist_done      = '0;
        bist_error     = '0;
        bist_correct   = '0;
        bist_error_cnt = '0;
        for (int k = 0; k < 16; k++) begin
            model[k] = '0;
        end
        model[0]  = `MBIST_RST_SW0;
        model[1]  = `MBIST_RST_SW1;
        model[9]  = `MBIST_RST_ID1;
        model[10] = `MBIST_RST_ID2;
        model[11] = `MBIST_RST_ID3;
        repeat (4) @(posedge mclk);
        #1;
        reset_n = 1'b1;
        @(posedge mclk);
        #1;

        // Reset values with status and serial words skipped
        for (int k = 0; k < 12; k++) begin
            if (k >= 4 && k <= 8) begin
                continue;
            end
            reg_read_check(mbist_cfg_pkg::reg_idx_t'(k), model[k]);
        end

        // Byte-enabled writes to words 0, 1, 9
        for (int n = 0; n < 9; n++) begin
            idx  = (n % 3 == 2) ? `MBIST_IDX_ID1 : mbist_cfg_pkg::reg_idx_t'(n % 3);
            data = $urandom();
            mask = $urandom();
            be   = mask[3:0];
            mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
            reg_write(idx, data, be);
            model[idx] = (model[idx] & ~mask) | (data & mask);
            reg_read_check(idx, model[idx]);
        end

        // Lane control nibbles
        data = $urandom();
        reg_write(`MBIST_IDX_LANE_CTRL, data, 4'hf);
        reg_read_check(`MBIST_IDX_LANE_CTRL, data);
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            exp_en[i]   = data[4*i];
            exp_run[i]  = data[4*i+1];
            exp_load[i] = data[4*i+2];
        end
        check_word("bist_en", 32'(bist_en), 32'(exp_en));
        check_word("bist_run", 32'(bist_run), 32'(exp_run));
        check_word("bist_load", 32'(bist_load), 32'(exp_load));

        // Status packing of lanes 0..3 then 4..7
        data         = $urandom();
        bist_done    = data[7:0];
        bist_error   = data[15:8];
        bist_correct = data[23:16];
        data         = $urandom();
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            bist_error_cnt[i] = data[4*i +: 4];
        end
        reg_read_check(`MBIST_IDX_STATUS0, status_word(0));
        reg_read_check(`MBIST_IDX_STATUS1, status_word(4));

        // Serial round trips on three distinct lanes
        data = $urandom();
        lane = int'(data[2:0]);
        for (int r = 0; r < 3; r++) begin
            lane_mask = mbist_cfg_pkg::lane_vec_t'(1) << lane;
            reg_write(`MBIST_IDX_LANE_SEL, 32'(lane), 4'h1);
            reg_read_check(`MBIST_IDX_SER_RD, chain_init[lane]);
            check_word("bist_shift lanes", 32'(seen_shift), 32'(lane_mask));
            data = $urandom();
            reg_write(`MBIST_IDX_SER_WR, data, 4'hf);
            check_word("bist_shift lanes", 32'(seen_shift), 32'(lane_mask));
            check_word("bist_sdi other lanes", 32'(seen_sdi & ~lane_mask), 32'h0);
            reg_read_check(`MBIST_IDX_SER_RD, data);
            // Capture only without shifting
            reg_read_check(`MBIST_IDX_SER_LAST, data);
            check_word("bist_shift lanes", 32'(seen_shift), 32'h0);
            lane = (lane + 3) % 8;
        end

        // No lane selected
        reg_write(`MBIST_IDX_LANE_SEL, 32'h9, 4'h1);
        reg_read_check(`MBIST_IDX_SER_RD, 32'h0);
        check_word("bist_shift lanes", 32'(seen_shift), 32'h0);

        $display("Check errors: %0d, assertion failures: %0d", errors,
                 mbist_cfg_top_inst.u_assertions.fail_total);
        if (errors == 0 && mbist_cfg_top_inst.u_assertions.fail_total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog/mbist_cfg_regs.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module mbist_cfg_regs (
    input  logic                                            mclk,
    input  logic                                            reset_n,
    // Write request and read index
    input  mbist_cfg_pkg::reg_wr_t                          regs_wr,
    input  mbist_cfg_pkg::reg_idx_t                         regs_idx,
    output mbist_cfg_pkg::reg_word_t                        regs_rdata,
    // Last word from the serial port
    input  mbist_cfg_pkg::reg_word_t                        ser_last,
    output mbist_cfg_pkg::lane_sel_t                        lane_sel,
    // Per-lane control
    output mbist_cfg_pkg::lane_vec_t                        bist_en,
    output mbist_cfg_pkg::lane_vec_t                        bist_run,
    output mbist_cfg_pkg::lane_vec_t                        bist_load,
    // Per-lane status
    input  mbist_cfg_pkg::lane_vec_t                        bist_done,
    input  mbist_cfg_pkg::lane_vec_t                        bist_error,
    input  mbist_cfg_pkg::lane_vec_t                        bist_correct,
    input  mbist_cfg_pkg::err_cnt_t [`MBIST_NUM_LANES-1:0]  bist_error_cnt
);

    // Software and identification words
    mbist_cfg_pkg::reg_word_t sw0;
    mbist_cfg_pkg::reg_word_t sw1;
    mbist_cfg_pkg::reg_word_t id1;
    mbist_cfg_pkg::reg_word_t id2;
    mbist_cfg_pkg::reg_word_t id3;
    // Word 3 as stored and as lane nibbles
    mbist_cfg_pkg::reg_word_t                                ctrl_word;
    mbist_cfg_pkg::bist_lane_ctrl_t   [`MBIST_NUM_LANES-1:0] lane_ctrl;
    // Status bytes for words 4 and 5
    mbist_cfg_pkg::bist_lane_status_t [`MBIST_NUM_LANES-1:0] lane_status;
    mbist_cfg_pkg::reg_word_t                                status_lo;
    mbist_cfg_pkg::reg_word_t                                status_hi;

    // Replace enabled bytes only
    function automatic mbist_cfg_pkg::reg_word_t be_merge(
        input mbist_cfg_pkg::reg_word_t cur,
        input mbist_cfg_pkg::reg_word_t data,
        input mbist_cfg_pkg::reg_be_t   be
    );
        mbist_cfg_pkg::reg_word_t res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            sw0       <= `MBIST_RST_SW0;
            sw1       <= `MBIST_RST_SW1;
            id1       <= `MBIST_RST_ID1;
            id2       <= `MBIST_RST_ID2;
            id3       <= `MBIST_RST_ID3;
            lane_sel  <= '0;
            ctrl_word <= '0;
        end else if (regs_wr.strobe) begin
            case (regs_wr.idx)
                `MBIST_IDX_SW0:       sw0 <= be_merge(sw0, regs_wr.data, regs_wr.be);
                `MBIST_IDX_SW1:       sw1 <= be_merge(sw1, regs_wr.data, regs_wr.be);
                `MBIST_IDX_ID1:       id1 <= be_merge(id1, regs_wr.data, regs_wr.be);
                `MBIST_IDX_ID2:       id2 <= be_merge(id2, regs_wr.data, regs_wr.be);
                `MBIST_IDX_ID3:       id3 <= be_merge(id3, regs_wr.data, regs_wr.be);
                `MBIST_IDX_LANE_CTRL: begin
                    ctrl_word <= be_merge(ctrl_word, regs_wr.data, regs_wr.be);
                end
                // Lane select sits in the low nibble of byte 0
                `MBIST_IDX_LANE_SEL: begin
                    if (regs_wr.be[0]) begin
                        lane_sel <= regs_wr.data[3:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------
    // Lane control and status
    // ------------------------------
    assign lane_ctrl = ctrl_word;

    always_comb begin
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            bist_en[i]   = lane_ctrl[i].en;
            bist_run[i]  = lane_ctrl[i].run;
            bist_load[i] = lane_ctrl[i].load;
        end
    end

    always_comb begin
        for (int i = 0; i < `MBIST_NUM_LANES; i++) begin
            lane_status[i].err_cnt = bist_error_cnt[i];
            lane_status[i].zero    = 1'b0;
            lane_status[i].correct = bist_correct[i];
            lane_status[i].error   = bist_error[i];
            lane_status[i].done    = bist_done[i];
        end
    end

    // Lower half of the lanes in word 4
    assign status_lo = lane_status[`MBIST_NUM_LANES/2-1:0];
    assign status_hi = lane_status[`MBIST_NUM_LANES-1:`MBIST_NUM_LANES/2];

    // ------------------------------
    // Read multiplexer
    // ------------------------------
    always_comb begin
        case (regs_idx)
            `MBIST_IDX_SW0:       regs_rdata = sw0;
            `MBIST_IDX_SW1:       regs_rdata = sw1;
            `MBIST_IDX_LANE_SEL:  regs_rdata = {28'h0, lane_sel};
            `MBIST_IDX_LANE_CTRL: regs_rdata = ctrl_word;
            `MBIST_IDX_STATUS0:   regs_rdata = status_lo;
            `MBIST_IDX_STATUS1:   regs_rdata = status_hi;
            // Word 7 without shifting and word 8 both give the last capture
            `MBIST_IDX_SER_RD:    regs_rdata = ser_last;
            `MBIST_IDX_SER_LAST:  regs_rdata = ser_last;
            `MBIST_IDX_ID1:       regs_rdata = id1;
            `MBIST_IDX_ID2:       regs_rdata = id2;
            `MBIST_IDX_ID3:       regs_rdata = id3;
            // Serial write word and unused words
            default:              regs_rdata = '0;
        endcase
    end

endmodule

/* verilog/mbist_cfg_top.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module mbist_cfg_top (
    input  logic                                            mclk,
    input  logic                                            reset_n,
    // Register bus
    input  logic                                            reg_cs,
    input  logic                                            reg_wr,
    input  mbist_cfg_pkg::reg_addr_t                        reg_addr,
    input  mbist_cfg_pkg::reg_word_t                        reg_wdata,
    input  mbist_cfg_pkg::reg_be_t                          reg_be,
    output mbist_cfg_pkg::reg_word_t                        reg_rdata,
    output logic                                            reg_ack,
    // BIST engine control
    output mbist_cfg_pkg::lane_vec_t                        bist_en,
    output mbist_cfg_pkg::lane_vec_t                        bist_run,
    output mbist_cfg_pkg::lane_vec_t                        bist_load,
    // BIST serial chain
    output mbist_cfg_pkg::lane_vec_t                        bist_sdi,
    output mbist_cfg_pkg::lane_vec_t                        bist_shift,
    input  mbist_cfg_pkg::lane_vec_t                        bist_sdo,
    // BIST engine status
    input  mbist_cfg_pkg::lane_vec_t                        bist_done,
    input  mbist_cfg_pkg::lane_vec_t                        bist_error,
    input  mbist_cfg_pkg::lane_vec_t                        bist_correct,
    input  mbist_cfg_pkg::err_cnt_t [`MBIST_NUM_LANES-1:0]  bist_error_cnt
);

    // Control to register file
    mbist_cfg_pkg::reg_wr_t   regs_wr;
    mbist_cfg_pkg::reg_idx_t  regs_idx;
    mbist_cfg_pkg::reg_word_t regs_rdata;
    // Control to serial port
    mbist_cfg_pkg::ser_cmd_t  ser_cmd;
    logic                     ser_done;
    mbist_cfg_pkg::reg_word_t ser_rdata;
    // Register file to serial port
    mbist_cfg_pkg::lane_sel_t lane_sel;

    mbist_reg_ctrl u_reg_ctrl (
        .mclk       (mclk),
        .reset_n    (reset_n),
        .reg_cs     (reg_cs),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_be     (reg_be),
        .reg_rdata  (reg_rdata),
        .reg_ack    (reg_ack),
        .regs_wr    (regs_wr),
        .regs_idx   (regs_idx),
        .regs_rdata (regs_rdata),
        .ser_cmd    (ser_cmd),
        .ser_done   (ser_done),
        .ser_rdata  (ser_rdata)
    );

    mbist_cfg_regs u_cfg_regs (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .regs_wr        (regs_wr),
        .regs_idx       (regs_idx),
        .regs_rdata     (regs_rdata),
        .ser_last       (ser_rdata),
        .lane_sel       (lane_sel),
        .bist_en        (bist_en),
        .bist_run       (bist_run),
        .bist_load      (bist_load),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt)
    );

    mbist_serial_port u_serial_port (
        .mclk       (mclk),
        .reset_n    (reset_n),
        .ser_cmd    (ser_cmd),
        .lane_sel   (lane_sel),
        .ser_done   (ser_done),
        .ser_rdata  (ser_rdata),
        .bist_sdi   (bist_sdi),
        .bist_shift (bist_shift),
        .bist_sdo   (bist_sdo)
    );

endmodule

/* verilog/mbist_reg_ctrl.sv */
`timescale 1ns/1ps
`include "mbist_cfg_settings.svh"

module mbist_reg_ctrl (
    input  logic                     mclk,
    input  logic                     reset_n,
    // Register bus
    input  logic                     reg_cs,
    input  logic                     reg_wr,
    input  mbist_cfg_pkg::reg_addr_t reg_addr,
    input  mbist_cfg_pkg::reg_word_t reg_wdata,
    input  mbist_cfg_pkg::reg_be_t   reg_be,
    output mbist_cfg_pkg::reg_word_t reg_rdata,
    output logic                     reg_ack,
    // Register file side
    output mbist_cfg_pkg::reg_wr_t   regs_wr,
    output mbist_cfg_pkg::reg_idx_t  regs_idx,
    input  mbist_cfg_pkg::reg_word_t regs_rdata,
    // Serial port side
    output mbist_cfg_pkg::ser_cmd_t  ser_cmd,
    input  logic                     ser_done,
    input  mbist_cfg_pkg::reg_word_t ser_rdata
);

    mbist_cfg_pkg::reg_idx_t idx;
    logic                    req;
    logic                    req_d;
    logic                    req_edge;
    logic                    ser_acc;
    logic                    reg_done;

    // ------------------------------
    // Decode
    // ------------------------------
    // Word address only
    assign idx      = reg_addr[5:2];
    assign regs_idx = idx;

    // Serial write on word 6 or serial read on word 7
    assign ser_acc = (reg_wr && (idx == `MBIST_IDX_SER_WR))
                  || (!reg_wr && (idx == `MBIST_IDX_SER_RD));

    // ------------------------------
    // Request edge
    // ------------------------------
    // Request drops once ack is seen
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            req   <= 1'b0;
            req_d <= 1'b0;
        end else begin
            req   <= reg_cs & ~reg_ack;
            req_d <= req;
        end
    end

    // One cycle per request
    assign req_edge = req & ~req_d;
    // Plain register access completes on the edge
    assign reg_done = req_edge & ~ser_acc;

    // Register write strobe
    always_comb begin
        regs_wr.strobe = reg_done & reg_wr;
        regs_wr.idx    = idx;
        regs_wr.data   = reg_wdata;
        regs_wr.be     = reg_be;
    end

    // Serial start with load word
    always_comb begin
        ser_cmd.start   = req_edge & ser_acc;
        ser_cmd.rd_n_wr = ~reg_wr;
        ser_cmd.data    = reg_wdata;
    end

    // ------------------------------
    // Response
    // ------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= reg_done | ser_done;
        end
    end

    // Read word lands together with ack
    always_ff @(posedge mclk) begin
        if (ser_done) begin
            reg_rdata <= ser_rdata;
        end else if (reg_done) begin
            reg_rdata <= regs_rdata;
        end
    end

endmodule
